// File: filelist.f
src/mem_pkg.sv
src/mem_issue.sv
src/load_store_unit.sv
src/data_ram.sv
src/load_writeback.sv
src/mem_stage_top.sv
testbench/mem_stage_props.sv
testbench/tb_mem_stage.sv

// File: Makefile
TOP  := tb_mem_stage
SRCS := $(shell cat filelist.f)

.PHONY: run clean

# Run the simulation and decide pass or fail from the log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    mem_pkg::opcode_t  req_opcode;
    mem_pkg::funct3_t  req_funct3;
    mem_pkg::word_t    req_base;
    mem_pkg::offset_t  req_offset;
    mem_pkg::word_t    req_store_data;
    mem_pkg::reg_idx_t req_rd;
    logic              wb_valid;
    mem_pkg::reg_idx_t wb_rd;
    mem_pkg::word_t    wb_data;
    logic              misaligned;
    mem_pkg::word_t    misaligned_addr;

    integer         seed = 32'h4d37;
    int             err_count = 0;
    int             n_loads = 0;
    int             n_stores = 0;
    int             n_mis = 0;
    logic [7:0]     shadow [mem_pkg::ram_words*4];   // Byte image of the RAM
    mem_pkg::word_t model_addr;

    // Expected load results, one stage per DUT edge
    logic              exp_v0, exp_v1, exp_wb_v;
    mem_pkg::word_t    exp_d0, exp_d1, exp_wb_data;
    mem_pkg::reg_idx_t exp_rd0, exp_rd1, exp_wb_rd;
    logic              exp_mis_v;
    mem_pkg::word_t    exp_mis_addr;

    always #10 clk = ~clk;

    mem_stage_top i_mem_stage_top (.*);

    bind mem_stage_top mem_stage_props i_mem_stage_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .iss_valid  (iss_valid),
        .ram_en     (ram_en),
        .load_req   (load_req),
        .misaligned (misaligned),
        .wb_valid   (wb_valid)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic mem_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int access_bytes(input mem_pkg::funct3_t f3);
        case (f3)
            mem_pkg::f3_half, mem_pkg::f3_half_u : return 2;
            mem_pkg::f3_word                     : return 4;
            default                              : return 1;
        endcase
    endfunction

    // Stores have no unsigned forms
    function automatic logic is_access(input mem_pkg::opcode_t opc, input mem_pkg::funct3_t f3);
        if (opc == mem_pkg::opc_store)
            return f3 inside {mem_pkg::f3_byte, mem_pkg::f3_half, mem_pkg::f3_word};
        return (opc == mem_pkg::opc_load)
            && (f3 inside {mem_pkg::f3_byte, mem_pkg::f3_half, mem_pkg::f3_word,
                           mem_pkg::f3_byte_u, mem_pkg::f3_half_u});
    endfunction

    // Little endian gather, then extension
    function automatic mem_pkg::word_t load_value(input mem_pkg::funct3_t f3,
                                                  input mem_pkg::word_t a);
        mem_pkg::word_t v;
        v = '0;
        for (int i = 0; i < access_bytes(f3); i++) begin
            v[i*8 +: 8] = shadow[int'(a[9:0]) + i];
        end
        if (f3 == mem_pkg::f3_byte)
            v = {{24{v[7]}}, v[7:0]};
        else if (f3 == mem_pkg::f3_half)
            v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_v0    <= 1'b0;
            exp_v1    <= 1'b0;
            exp_wb_v  <= 1'b0;
            exp_mis_v <= 1'b0;
        end else begin
            exp_v0    <= 1'b0;
            exp_mis_v <= 1'b0;
            if (req_valid && is_access(req_opcode, req_funct3)) begin
                model_addr = req_base + {{20{req_offset[11]}}, req_offset};
                if (model_addr % access_bytes(req_funct3) != 0) begin
                    exp_mis_v    <= 1'b1;
                    exp_mis_addr <= model_addr;
                    n_mis++;
                end else if (req_opcode == mem_pkg::opc_load) begin
                    exp_v0  <= 1'b1;
                    exp_d0  <= load_value(req_funct3, model_addr);
                    exp_rd0 <= req_rd;
                    n_loads++;
                end else begin
                    for (int i = 0; i < access_bytes(req_funct3); i++) begin
                        shadow[int'(model_addr[9:0]) + i] = req_store_data[i*8 +: 8];
                    end
                    n_stores++;
                end
            end
            exp_v1      <= exp_v0;
            exp_d1      <= exp_d0;
            exp_rd1     <= exp_rd0;
            exp_wb_v    <= exp_v1;
            exp_wb_data <= exp_d1;
            exp_wb_rd   <= exp_rd1;
        end
    end

    //////////////////////////////////////////////////
    // Checks against the model
    //////////////////////////////////////////////////

    task automatic log_mismatch(input string sig, input mem_pkg::word_t got,
                                input mem_pkg::word_t expected);
        err_count++;
        $display("Error: %0t ns %s got %h expected %h", $time, sig, got, expected);
    endtask

    a_wb_valid : assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_wb_v)
        else log_mismatch("wb_valid", 32'($sampled(wb_valid)), 32'($sampled(exp_wb_v)));
    a_wb_data : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && exp_wb_v |-> wb_data == exp_wb_data)
        else log_mismatch("wb_data", $sampled(wb_data), $sampled(exp_wb_data));
    a_wb_rd : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && exp_wb_v |-> wb_rd == exp_wb_rd)
        else log_mismatch("wb_rd", 32'($sampled(wb_rd)), 32'($sampled(exp_wb_rd)));
    a_misaligned : assert property (@(posedge clk) disable iff (!rst_n) misaligned == exp_mis_v)
        else log_mismatch("misaligned", 32'($sampled(misaligned)), 32'($sampled(exp_mis_v)));
    a_mis_addr : assert property (@(posedge clk) disable iff (!rst_n)
        exp_mis_v |-> misaligned_addr == exp_mis_addr)
        else log_mismatch("misaligned_addr", $sampled(misaligned_addr), $sampled(exp_mis_addr));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Random offset, base chosen so that the sum lands on a
    task automatic send_req(input mem_pkg::opcode_t opc, input mem_pkg::funct3_t f3,
                            input mem_pkg::word_t a, input mem_pkg::word_t data);
        mem_pkg::word_t r;
        r = rand_word();
        @(posedge clk);
        req_valid      <= 1'b1;
        req_opcode     <= opc;
        req_funct3     <= f3;
        req_offset     <= r[11:0];
        req_base       <= a - {{20{r[11]}}, r[11:0]};
        req_store_data <= data;
        req_rd         <= r[16:12];
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    function automatic mem_pkg::funct3_t pick_load_f3(input logic [1:0] sel);
        case (sel)
            2'd0    : return mem_pkg::f3_byte;
            2'd1    : return mem_pkg::f3_half;
            2'd2    : return mem_pkg::f3_byte_u;
            default : return mem_pkg::f3_half_u;
        endcase
    endfunction

    function automatic mem_pkg::word_t align_to(input mem_pkg::funct3_t f3,
                                                input mem_pkg::word_t a);
        return a & ~(mem_pkg::word_t'(access_bytes(f3) - 1));
    endfunction

    initial begin
        mem_pkg::word_t   r;
        mem_pkg::word_t   a;
        mem_pkg::funct3_t f3;
        int               drain;
        int               prop_fails;
        rst_n          <= 1'b0;
        req_valid      <= 1'b0;
        req_opcode     <= '0;
        req_funct3     <= '0;
        req_base       <= '0;
        req_offset     <= '0;
        req_store_data <= '0;
        req_rd         <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);

        // Fill words 0 to 63, then read them back
        for (int w = 0; w < 64; w++) begin
            send_req(mem_pkg::opc_store, mem_pkg::f3_word, w*4, rand_word());
        end
        for (int w = 0; w < 64; w++) begin
            send_req(mem_pkg::opc_load, mem_pkg::f3_word, w*4, '0);
        end
        idle(1);

        for (int k = 0; k < 200; k++) begin
            r  = rand_word();
            f3 = r[0] ? (r[1] ? mem_pkg::f3_half : mem_pkg::f3_byte) : pick_load_f3(r[2:1]);
            a  = align_to(f3, {24'b0, r[15:8]});   // Stays inside the filled region
            send_req(r[0] ? mem_pkg::opc_store : mem_pkg::opc_load, f3, a, rand_word());
            if (r[31]) idle(1);
        end

        // Misaligned traffic with an OP-IMM request mixed in
        for (int k = 0; k < 24; k++) begin
            r = rand_word();
            a = {24'b0, r[7:2], 2'b00};
            if (r[0])
                a = a | {30'b0, r[8], 1'b1};
            else
                a = a | {30'b0, (r[9:8] == 2'b00) ? 2'b10 : r[9:8]};
            f3 = r[0] ? mem_pkg::f3_half : mem_pkg::f3_word;
            send_req(r[1] ? mem_pkg::opc_store : mem_pkg::opc_load, f3, a, rand_word());
            if (r[2]) send_req(7'b0010011, mem_pkg::f3_word, a, rand_word());
        end
        for (int w = 0; w < 16; w++) begin
            send_req(mem_pkg::opc_load, mem_pkg::f3_word, w*4, '0);
        end

        // Store then load of the same word on consecutive cycles
        for (int k = 0; k < 30; k++) begin
            r  = rand_word();
            f3 = (r[1:0] == 2'b11) ? mem_pkg::f3_word
                                   : (r[0] ? mem_pkg::f3_half : mem_pkg::f3_byte);
            a  = align_to(f3, {24'b0, r[15:8]});
            send_req(mem_pkg::opc_store, f3, a, rand_word());
            f3 = (r[17:16] == 2'b11) ? mem_pkg::f3_word : pick_load_f3(r[19:18]);
            send_req(mem_pkg::opc_load, f3, align_to(f3, {a[31:2], r[21:20]}), '0);
        end
        idle(2);

        drain = 0;
        while ((exp_v0 || exp_v1 || exp_wb_v || wb_valid) && drain < 20) begin
            @(posedge clk);
            drain++;
        end
        if (drain >= 20) begin
            $display("Timeout: loads still in flight after 20 idle cycles");
            $display("=== FAIL ===");
            $finish;
        end else begin
            repeat (2) @(posedge clk);   // Let the last checks fire
            prop_fails = i_mem_stage_top.i_mem_stage_props.fail_count;
            $display("Summary: %0d stores, %0d loads, %0d misaligned, %0d errors, %0d from props",
                     n_stores, n_loads, n_mis, err_count + prop_fails, prop_fails);
            if (err_count + prop_fails == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_stage_props.sv
`default_nettype none

module mem_stage_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic req_valid,
    input wire logic iss_valid,
    input wire logic ram_en,
    input wire logic load_req,
    input wire logic misaligned,
    input wire logic wb_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    //////////////////////////////////////////////////
    // Reset behavior
    //////////////////////////////////////////////////

    p_reset_quiet : assert property (@(posedge clk) !rst_n |-> !wb_valid && !misaligned)
        else begin
            fail_count++;
            $error("wb_valid or misaligned high during reset");
        end

    p_release_quiet : assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_valid && !misaligned && !iss_valid)
        else begin
            fail_count++;
            $error("pipeline not idle after reset release");
        end

    //////////////////////////////////////////////////
    // Issue and load timing
    //////////////////////////////////////////////////

    p_issue_follows : assert property (@(posedge clk) disable iff (!rst_n)
        iss_valid == $past(req_valid))
        else begin
            fail_count++;
            $error("iss_valid does not follow req_valid by one edge");
        end

    // Load result two edges after the RAM read request
    p_load_latency : assert property (@(posedge clk) disable iff (!rst_n)
        load_req |-> ##2 wb_valid)
        else begin
            fail_count++;
            $error("aligned load produced no wb_valid two edges later");
        end

    p_no_spurious_wb : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(load_req, 2))
        else begin
            fail_count++;
            $error("wb_valid without a matching load");
        end

    //////////////////////////////////////////////////
    // Misaligned accesses
    //////////////////////////////////////////////////

    p_mis_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
        misaligned |-> iss_valid)
        else begin
            fail_count++;
            $error("misaligned raised with no issued request");
        end

    p_mis_no_access : assert property (@(posedge clk) disable iff (!rst_n)
        misaligned |-> !ram_en && !load_req)
        else begin
            fail_count++;
            $error("misaligned access reached the RAM");
        end

    p_mis_no_wb : assert property (@(posedge clk) disable iff (!rst_n)
        misaligned |-> ##2 !wb_valid)
        else begin
            fail_count++;
            $error("misaligned access produced wb_valid");
        end

endmodule

`default_nettype wire

// File: src/mem_stage_top.sv
`default_nettype none

module mem_stage_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req_valid,
    input  wire mem_pkg::opcode_t  req_opcode,
    input  wire mem_pkg::funct3_t  req_funct3,
    input  wire mem_pkg::word_t    req_base,
    input  wire mem_pkg::offset_t  req_offset,
    input  wire mem_pkg::word_t    req_store_data,
    input  wire mem_pkg::reg_idx_t req_rd,
    output logic                   wb_valid,
    output mem_pkg::reg_idx_t      wb_rd,
    output mem_pkg::word_t         wb_data,
    output logic                   misaligned,
    output mem_pkg::word_t         misaligned_addr
);

    // Issue register outputs
    logic               iss_valid;
    mem_pkg::opcode_t   iss_opcode;
    mem_pkg::funct3_t   iss_funct3;
    mem_pkg::word_t     iss_addr;
    mem_pkg::word_t     iss_store_data;
    mem_pkg::reg_idx_t  iss_rd;

    // RAM port
    logic               ram_en;
    logic               ram_write;
    mem_pkg::ram_addr_t ram_addr;
    mem_pkg::mask_t     ram_mask;
    mem_pkg::word_t     ram_wdata;
    mem_pkg::word_t     ram_rdata;
    logic               load_req;

    mem_issue i_mem_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_opcode     (req_opcode),
        .req_funct3     (req_funct3),
        .req_base       (req_base),
        .req_offset     (req_offset),
        .req_store_data (req_store_data),
        .req_rd         (req_rd),
        .iss_valid      (iss_valid),
        .iss_opcode     (iss_opcode),
        .iss_funct3     (iss_funct3),
        .iss_addr       (iss_addr),
        .iss_store_data (iss_store_data),
        .iss_rd         (iss_rd)
    );

    load_store_unit i_load_store_unit (
        .iss_valid       (iss_valid),
        .iss_opcode      (iss_opcode),
        .iss_funct3      (iss_funct3),
        .iss_addr        (iss_addr),
        .iss_store_data  (iss_store_data),
        .ram_en          (ram_en),
        .ram_write       (ram_write),
        .ram_addr        (ram_addr),
        .ram_mask        (ram_mask),
        .ram_wdata       (ram_wdata),
        .load_req        (load_req),
        .misaligned      (misaligned),
        .misaligned_addr (misaligned_addr)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_write (ram_write),
        .ram_addr  (ram_addr),
        .ram_mask  (ram_mask),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    load_writeback i_load_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .iss_funct3 (iss_funct3),
        .iss_addr   (iss_addr),
        .iss_rd     (iss_rd),
        .ram_rdata  (ram_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// File: src/load_writeback.sv
`default_nettype none

module load_writeback (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              load_req,
    input  wire mem_pkg::funct3_t  iss_funct3,
    input  wire mem_pkg::word_t    iss_addr,
    input  wire mem_pkg::reg_idx_t iss_rd,
    input  wire mem_pkg::word_t    ram_rdata,
    output logic                   wb_valid,
    output mem_pkg::reg_idx_t      wb_rd,
    output mem_pkg::word_t         wb_data
);

    logic              ld_pending;
    mem_pkg::funct3_t  ld_funct3;
    logic [1:0]        ld_offset;
    mem_pkg::reg_idx_t ld_rd;
    mem_pkg::word_t    lane_word;
    mem_pkg::word_t    ext_data;

    //////////////////////////////////////////////////
    // Stage one alongside the RAM read
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_pending <= 1'b0;
            ld_funct3  <= '0;
            ld_offset  <= '0;
            ld_rd      <= '0;
        end else begin
            ld_pending <= load_req;
            if (load_req) begin
                ld_funct3 <= iss_funct3;
                ld_offset <= iss_addr[1:0];   // Byte lane within the word
                ld_rd     <= iss_rd;
            end
        end
    end

    // Addressed lane brought down to bit 0
    assign lane_word = ram_rdata >> {ld_offset, 3'b000};

    always_comb begin
        case (ld_funct3)
            mem_pkg::f3_byte   : ext_data = {{24{lane_word[7]}}, lane_word[7:0]};
            mem_pkg::f3_half   : ext_data = {{16{lane_word[15]}}, lane_word[15:0]};
            mem_pkg::f3_byte_u : ext_data = {24'b0, lane_word[7:0]};
            mem_pkg::f3_half_u : ext_data = {16'b0, lane_word[15:0]};
            default            : ext_data = ram_rdata;   // LW
        endcase
    end

    // Stage two, write-back register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= ld_pending;
            if (ld_pending) begin
                wb_rd   <= ld_rd;
                wb_data <= ext_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/data_ram.sv
`default_nettype none

module data_ram (
    input  wire logic               clk,
    input  wire logic               ram_en,
    input  wire logic               ram_write,
    input  wire mem_pkg::ram_addr_t ram_addr,
    input  wire mem_pkg::mask_t     ram_mask,
    input  wire mem_pkg::word_t     ram_wdata,
    output mem_pkg::word_t          ram_rdata
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Contents start undefined
    mem_pkg::word_t mem [mem_pkg::ram_words];

    //////////////////////////////////////////////////
    // Byte-lane write and registered read
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_write) begin
                // Each lane written on its own enable
                for (int lane = 0; lane < 4; lane++) begin
                    if (ram_mask[lane]) begin
                        mem[ram_addr][lane*8 +: 8] <= ram_wdata[lane*8 +: 8];
                    end
                end
            end else begin
                ram_rdata <= mem[ram_addr];   // Whole word, lane picked downstream
            end
        end
    end

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  wire logic              iss_valid,
    input  wire mem_pkg::opcode_t  iss_opcode,
    input  wire mem_pkg::funct3_t  iss_funct3,
    input  wire mem_pkg::word_t    iss_addr,
    input  wire mem_pkg::word_t    iss_store_data,

    // RAM port
    output logic                   ram_en,
    output logic                   ram_write,
    output mem_pkg::ram_addr_t     ram_addr,
    output mem_pkg::mask_t         ram_mask,
    output mem_pkg::word_t         ram_wdata,

    // Status
    output logic                   load_req,
    output logic                   misaligned,
    output mem_pkg::word_t         misaligned_addr
);

    logic is_load;
    logic is_store;
    logic acc_byte;
    logic acc_half;
    logic acc_word;
    logic access;
    logic aligned;

    assign is_load  = iss_valid && (iss_opcode == mem_pkg::opc_load);
    assign is_store = iss_valid && (iss_opcode == mem_pkg::opc_store);

    //////////////////////////////////////////////////
    // Width decode
    //////////////////////////////////////////////////

    always_comb begin
        acc_byte = 1'b0;
        acc_half = 1'b0;
        acc_word = 1'b0;
        case (iss_funct3)
            mem_pkg::f3_byte   : acc_byte = is_load || is_store;
            mem_pkg::f3_half   : acc_half = is_load || is_store;
            mem_pkg::f3_word   : acc_word = is_load || is_store;
            mem_pkg::f3_byte_u : acc_byte = is_load;   // Unsigned forms exist for loads only
            mem_pkg::f3_half_u : acc_half = is_load;
            default            : ;                     // Reserved code, no access
        endcase
    end

    assign access = acc_byte || acc_half || acc_word;

    // Bytes never fault
    assign aligned = acc_byte
                  || (acc_half && !iss_addr[0])
                  || (acc_word && (iss_addr[1:0] == 2'b00));

    assign misaligned      = access && !aligned;
    assign misaligned_addr = iss_addr;

    //////////////////////////////////////////////////
    // RAM request
    //////////////////////////////////////////////////

    assign ram_en    = access && aligned;
    assign ram_write = is_store;
    assign load_req  = is_load && ram_en;
    assign ram_addr  = iss_addr[mem_pkg::ram_addr_bits+1:2];   // Drop the lane offset

    // Lane enables
    always_comb begin
        if (acc_word) begin
            ram_mask = 4'b1111;
        end else if (acc_half) begin
            ram_mask = {{2{iss_addr[1]}}, {2{~iss_addr[1]}}};
        end else begin
            ram_mask = {
                 iss_addr[1] &  iss_addr[0],
                 iss_addr[1] & ~iss_addr[0],
                ~iss_addr[1] &  iss_addr[0],
                ~iss_addr[1] & ~iss_addr[0]
            };
        end
    end

    // Low bytes of rs2 moved up to the addressed lane, mask drops the rest
    assign ram_wdata = iss_store_data << {iss_addr[1:0], 3'b000};

endmodule

`default_nettype wire

// File: src/mem_issue.sv
`default_nettype none

module mem_issue (
    input  wire logic              clk,
    input  wire logic              rst_n,

    // Incoming request strobe and payload
    input  wire logic              req_valid,
    input  wire mem_pkg::opcode_t  req_opcode,
    input  wire mem_pkg::funct3_t  req_funct3,
    input  wire mem_pkg::word_t    req_base,
    input  wire mem_pkg::offset_t  req_offset,
    input  wire mem_pkg::word_t    req_store_data,
    input  wire mem_pkg::reg_idx_t req_rd,

    // Registered request toward the load/store unit
    output mem_pkg::opcode_t       iss_opcode,
    output logic                   iss_valid,
    output mem_pkg::funct3_t       iss_funct3,
    output mem_pkg::word_t         iss_addr,
    output mem_pkg::word_t         iss_store_data,
    output mem_pkg::reg_idx_t      iss_rd
);

    mem_pkg::word_t offset_ext;
    mem_pkg::word_t eff_addr;

    // Immediate is sign extended to the full address width
    assign offset_ext = {{20{req_offset[11]}}, req_offset};
    assign eff_addr   = req_base + offset_ext;

    //////////////////////////////////////////////////
    // Request register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid      <= 1'b0;
            iss_opcode     <= '0;
            iss_funct3     <= '0;
            iss_addr       <= '0;
            iss_store_data <= '0;
            iss_rd         <= '0;
        end else begin
            iss_valid <= req_valid;   // One cycle per strobe
            if (req_valid) begin
                // Any opcode is captured, the decoder filters it
                iss_opcode     <= req_opcode;
                iss_funct3     <= req_funct3;
                iss_addr       <= eff_addr;
                iss_store_data <= req_store_data;
                iss_rd         <= req_rd;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    typedef logic [6:0]         opcode_t;    // RV32I major opcode
    typedef logic [2:0]         funct3_t;    // Access width and sign
    typedef logic [31:0]        word_t;      // Data or byte address
    typedef logic signed [11:0] offset_t;    // I/S-type immediate
    typedef logic [3:0]         mask_t;      // Bit 0 is the lowest byte address
    typedef logic [4:0]         reg_idx_t;   // Destination register

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////

    // Only the two memory opcodes are decoded in this stage
    localparam opcode_t opc_load  = 7'b00_000_11;
    localparam opcode_t opc_store = 7'b01_000_11;

    //////////////////////////////////////////////////
    // funct3 access codes
    //////////////////////////////////////////////////

    // Bit 2 selects zero extension on loads
    localparam funct3_t f3_byte   = 3'b000;   // LB / SB
    localparam funct3_t f3_half   = 3'b001;   // LH / SH
    localparam funct3_t f3_word   = 3'b010;   // LW / SW
    localparam funct3_t f3_byte_u = 3'b100;   // LBU
    localparam funct3_t f3_half_u = 3'b101;   // LHU

    //////////////////////////////////////////////////
    // Data RAM geometry
    //////////////////////////////////////////////////

    localparam int ram_words     = 256;
    localparam int ram_addr_bits = $clog2(ram_words);

    // Word index taken from byte address bits above the lane offset
    typedef logic [ram_addr_bits-1:0] ram_addr_t;

endpackage

`default_nettype wire
